/* hw/dp_defs.svh */
`ifndef DP_DEFS_SVH
`define DP_DEFS_SVH

// Datapath word width
`define DP_XLEN 32

// Architectural registers, r15 is a plain register here
`define DP_NREGS 16

`endif

/* hw/dpPkg.sv */
package dpPkg;

  // Data-processing opcodes in ARM numbering
  typedef enum logic [3:0] {
    opAnd = 4'd0,
    opEor = 4'd1,
    opSub = 4'd2,
    opRsb = 4'd3,
    opAdd = 4'd4,
    opAdc = 4'd5,
    opSbc = 4'd6,
    opRsc = 4'd7,
    opTst = 4'd8,
    opTeq = 4'd9,
    opCmp = 4'd10,
    opCmn = 4'd11,
    opOrr = 4'd12,
    opMov = 4'd13,
    opBic = 4'd14,
    opMvn = 4'd15
  } aluOp_e;

  // Immediate shift kinds, encoding of instr[6:5]
  typedef enum logic [1:0] {
    shLsl = 2'd0,
    shLsr = 2'd1,
    shAsr = 2'd2,
    shRor = 2'd3
  } shiftType_e;

  // NZCV, n in the top bit
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // Operand 2 as rotated immediate (I = 1)
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] cls;
    logic       immBit;
    aluOp_e     opcode;
    logic       sBit;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] rot;
    logic [7:0] imm8;
  } immVar_t;

  // Operand 2 as register shifted by immediate (I = 0)
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] cls;
    logic       immBit;
    aluOp_e     opcode;
    logic       sBit;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [4:0] shiftAmt;
    shiftType_e shiftType;
    logic       regShift;
    logic [3:0] rm;
  } regVar_t;

  // One instruction word, the I bit picks the view
  typedef union packed {
    immVar_t immVar;
    regVar_t regVar;
  } instrWord_u;

endpackage

/* hw/stageIf.sv */
`timescale 1ns/1ps
`include "dp_defs.svh"

// Decode to execute pipeline bundle
interface stageIf;

  // Control
  logic                valid;
  dpPkg::aluOp_e       op;
  logic                setFlags;
  logic                writesRd;

  // Register indices, kept for forwarding compares
  logic [3:0]          rd;
  logic [3:0]          rnIdx;
  logic [3:0]          rmIdx;

  // Operand values as read in decode
  logic [`DP_XLEN-1:0] rnVal;
  logic [`DP_XLEN-1:0] rmVal;

  // Operand 2 selection and shift controls
  logic                useImm;
  logic [`DP_XLEN-1:0] immVal;
  logic                immRotated;
  dpPkg::shiftType_e   shiftType;
  logic [4:0]          shiftAmt;

  modport dec (output valid, op, setFlags, writesRd, rd, rnIdx, rmIdx, rnVal, rmVal,
               useImm, immVal, immRotated, shiftType, shiftAmt);
  modport exe (input valid, op, setFlags, writesRd, rd, rnIdx, rmIdx, rnVal, rmVal,
               useImm, immVal, immRotated, shiftType, shiftAmt);

endinterface

/* hw/regFile.sv */
`timescale 1ns/1ps
`include "dp_defs.svh"

module regFile (
  input  logic                clk,
  input  logic                arstN,
  input  logic                wrEn,
  input  logic [3:0]          wrAddr,
  input  logic [`DP_XLEN-1:0] wrData,
  input  logic [3:0]          rdAddrA,
  input  logic [3:0]          rdAddrB,
  output logic [`DP_XLEN-1:0] rdDataA,
  output logic [`DP_XLEN-1:0] rdDataB
);

  logic [`DP_XLEN-1:0] regs [`DP_NREGS];

  // Storage, all registers start at zero
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `DP_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Combinational reads
  // Same-cycle write passes straight through, covers the distance-2 dependency
  always_comb begin
    rdDataA = regs[rdAddrA];
    rdDataB = regs[rdAddrB];
    if (wrEn && (wrAddr == rdAddrA)) begin
      rdDataA = wrData;
    end
    if (wrEn && (wrAddr == rdAddrB)) begin
      rdDataB = wrData;
    end
  end

endmodule

/* hw/operandDecode.sv */
`timescale 1ns/1ps
`include "dp_defs.svh"

module operandDecode (
  input  logic                clk,
  input  logic                arstN,
  input  logic                issue,
  input  dpPkg::instrWord_u   instr,
  input  logic [`DP_XLEN-1:0] rdDataA,
  input  logic [`DP_XLEN-1:0] rdDataB,
  output logic [3:0]          rdAddrA,
  output logic [3:0]          rdAddrB,
  stageIf.dec                 dec
);

  logic [2*`DP_XLEN-1:0] immPair;
  logic [`DP_XLEN-1:0]   immRot;
  logic [4:0]            rotAmt;
  logic                  writesRd;

  // ==============================
  // Field split and register read
  // ==============================

  // Rn is common to both views
  assign rdAddrA = instr.immVar.rn;
  // Rm only meaningful when I = 0, read anyway
  assign rdAddrB = instr.regVar.rm;

  // Rotated immediate, imm8 ror (2 * rot)
  assign rotAmt  = {instr.immVar.rot, 1'b0};
  // Doubled word shifted right, low half is the rotation
  assign immPair = {2{`DP_XLEN'(instr.immVar.imm8)}} >> rotAmt;
  assign immRot  = immPair[`DP_XLEN-1:0];

  // Compare ops only touch flags
  always_comb begin
    case (instr.immVar.opcode)
      dpPkg::opTst, dpPkg::opTeq, dpPkg::opCmp, dpPkg::opCmn: writesRd = 1'b0;
      default: writesRd = 1'b1;
    endcase
  end

  // ==============================
  // Decode to execute register
  // ==============================

  // Control, qualified by issue
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      dec.valid    <= 1'b0;
      dec.setFlags <= 1'b0;
      dec.writesRd <= 1'b0;
    end else begin
      dec.valid    <= issue;
      dec.setFlags <= issue & instr.immVar.sBit;
      dec.writesRd <= issue & writesRd;
    end
  end

  // Payload, only loaded on an issued instruction
  always_ff @(posedge clk) begin
    if (issue) begin
      dec.op         <= instr.immVar.opcode;
      dec.rd         <= instr.immVar.rd;
      dec.rnIdx      <= rdAddrA;
      dec.rmIdx      <= rdAddrB;
      dec.rnVal      <= rdDataA;
      dec.rmVal      <= rdDataB;
      dec.useImm     <= instr.immVar.immBit;
      dec.immVal     <= immRot;
      dec.immRotated <= (instr.immVar.rot != 4'd0);
      dec.shiftType  <= instr.regVar.shiftType;
      dec.shiftAmt   <= instr.regVar.shiftAmt;
    end
  end

endmodule

/* hw/barrelShifter.sv */
`timescale 1ns/1ps
`include "dp_defs.svh"

module barrelShifter (
  input  logic [`DP_XLEN-1:0] value,
  input  dpPkg::shiftType_e   shiftType,
  input  logic [4:0]          shiftAmt,
  input  logic                carryIn,
  output logic [`DP_XLEN-1:0] result,
  output logic                carryOut
);

  // Immediate-amount shifter, ARM encoding rules
  // Carry out is the last bit shifted out
  always_comb begin
    result   = value;
    carryOut = carryIn;
    case (shiftType)
      dpPkg::shLsl: begin
        // LSL #0 leaves value and carry alone
        if (shiftAmt != 5'd0) begin
          result   = value << shiftAmt;
          carryOut = value[`DP_XLEN - shiftAmt];
        end
      end
      dpPkg::shLsr: begin
        if (shiftAmt == 5'd0) begin
          // Encodes LSR #32
          result   = '0;
          carryOut = value[`DP_XLEN-1];
        end else begin
          result   = value >> shiftAmt;
          carryOut = value[shiftAmt - 1];
        end
      end
      dpPkg::shAsr: begin
        if (shiftAmt == 5'd0) begin
          // Encodes ASR #32, sign fills the word
          result   = {`DP_XLEN{value[`DP_XLEN-1]}};
          carryOut = value[`DP_XLEN-1];
        end else begin
          result   = $signed(value) >>> shiftAmt;
          carryOut = value[shiftAmt - 1];
        end
      end
      default: begin
        if (shiftAmt == 5'd0) begin
          // RRX, old C enters at the top
          result   = {carryIn, value[`DP_XLEN-1:1]};
          carryOut = value[0];
        end else begin
          result   = (value >> shiftAmt) | (value << (`DP_XLEN - shiftAmt));
          carryOut = value[shiftAmt - 1];
        end
      end
    endcase
  end

endmodule

/* hw/aluUnit.sv */
`timescale 1ns/1ps
`include "dp_defs.svh"

module aluUnit (
  input  dpPkg::aluOp_e       op,
  input  logic [`DP_XLEN-1:0] srcA,
  input  logic [`DP_XLEN-1:0] srcB,
  input  dpPkg::flags_t       flagsIn,
  input  logic                shiftCarry,
  output logic [`DP_XLEN-1:0] result,
  output dpPkg::flags_t       flagsOut
);

  logic                isArith;
  logic                invertB;
  logic                reverseInputs;
  logic                aluCarryIn;
  logic [`DP_XLEN-1:0] addA;
  logic [`DP_XLEN-1:0] rawB;
  logic [`DP_XLEN-1:0] addB;
  logic [`DP_XLEN:0]   sum;

  // ==============================
  // Adder control
  // ==============================

  // Subtract as A + ~B + 1, reverse ops swap first
  always_comb begin
    isArith       = 1'b1;
    invertB       = 1'b0;
    reverseInputs = 1'b0;
    aluCarryIn    = 1'b0;
    case (op)
      dpPkg::opAdd, dpPkg::opCmn: aluCarryIn = 1'b0;
      dpPkg::opAdc: aluCarryIn = flagsIn.c;
      dpPkg::opSub, dpPkg::opCmp: begin
        invertB    = 1'b1;
        aluCarryIn = 1'b1;
      end
      dpPkg::opSbc: begin
        invertB    = 1'b1;
        aluCarryIn = flagsIn.c;
      end
      dpPkg::opRsb: begin
        invertB       = 1'b1;
        reverseInputs = 1'b1;
        aluCarryIn    = 1'b1;
      end
      dpPkg::opRsc: begin
        invertB       = 1'b1;
        reverseInputs = 1'b1;
        aluCarryIn    = flagsIn.c;
      end
      default: isArith = 1'b0;
    endcase
  end

  // Single shared adder
  assign addA = reverseInputs ? srcB : srcA;
  assign rawB = reverseInputs ? srcA : srcB;
  assign addB = invertB ? ~rawB : rawB;
  assign sum  = {1'b0, addA} + {1'b0, addB} + {{`DP_XLEN{1'b0}}, aluCarryIn};

  // ==============================
  // Result and flags
  // ==============================

  always_comb begin
    case (op)
      dpPkg::opAnd, dpPkg::opTst: result = srcA & srcB;
      dpPkg::opEor, dpPkg::opTeq: result = srcA ^ srcB;
      dpPkg::opOrr: result = srcA | srcB;
      dpPkg::opMov: result = srcB;
      dpPkg::opBic: result = srcA & ~srcB;
      dpPkg::opMvn: result = ~srcB;
      default: result = sum[`DP_XLEN-1:0];
    endcase
  end

  // C = 1 means no borrow; logical ops keep V and take the shifter carry
  always_comb begin
    flagsOut.n = result[`DP_XLEN-1];
    flagsOut.z = (result == '0);
    flagsOut.c = isArith ? sum[`DP_XLEN] : shiftCarry;
    flagsOut.v = isArith ? ((addA[`DP_XLEN-1] == addB[`DP_XLEN-1]) &&
                            (sum[`DP_XLEN-1] != addA[`DP_XLEN-1])) : flagsIn.v;
  end

endmodule

/* hw/execStage.sv */
`timescale 1ns/1ps
`include "dp_defs.svh"

module execStage (
  input  logic                clk,
  input  logic                arstN,
  stageIf.exe                 exe,
  output logic                wrEn,
  output logic [3:0]          wrAddr,
  output logic [`DP_XLEN-1:0] wrData,
  output logic                retire,
  output logic [3:0]          retireRd,
  output logic [`DP_XLEN-1:0] retireData,
  output logic                retireWrite,
  output dpPkg::flags_t       flags
);

  logic                fwdA;
  logic                fwdB;
  logic [`DP_XLEN-1:0] srcA;
  logic [`DP_XLEN-1:0] srcReg;
  logic [`DP_XLEN-1:0] shiftOut;
  logic                shiftCarry;
  logic [`DP_XLEN-1:0] op2;
  logic                op2Carry;
  logic [`DP_XLEN-1:0] aluOut;
  dpPkg::flags_t       aluFlags;
  logic                wbValid;
  logic                wbWrites;
  logic [3:0]          wbRd;
  logic [`DP_XLEN-1:0] wbData;

  // ==============================
  // Operand forwarding
  // ==============================

  // Instruction one ahead sits in the writeback register
  assign fwdA   = wbWrites && (wbRd == exe.rnIdx);
  assign fwdB   = wbWrites && (wbRd == exe.rmIdx);
  assign srcA   = fwdA ? wbData : exe.rnVal;
  assign srcReg = fwdB ? wbData : exe.rmVal;

  // Shifter sees the current C for RRX and LSL #0
  barrelShifter uShifter (
    .value     (srcReg),
    .shiftType (exe.shiftType),
    .shiftAmt  (exe.shiftAmt),
    .carryIn   (flags.c),
    .result    (shiftOut),
    .carryOut  (shiftCarry)
  );

  // Operand 2 and its carry, immediate carry is bit 31 only after a rotation
  assign op2      = exe.useImm ? exe.immVal : shiftOut;
  assign op2Carry = exe.useImm ? (exe.immRotated ? exe.immVal[`DP_XLEN-1] : flags.c)
                               : shiftCarry;

  aluUnit uAlu (
    .op         (exe.op),
    .srcA       (srcA),
    .srcB       (op2),
    .flagsIn    (flags),
    .shiftCarry (op2Carry),
    .result     (aluOut),
    .flagsOut   (aluFlags)
  );

  // ==============================
  // Flags and writeback register
  // ==============================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags    <= '0;
      wbValid  <= 1'b0;
      wbWrites <= 1'b0;
    end else begin
      if (exe.valid && exe.setFlags) begin
        flags <= aluFlags;
      end
      wbValid  <= exe.valid;
      wbWrites <= exe.valid && exe.writesRd;
    end
  end

  // Result kept for compares too, retire reports it
  always_ff @(posedge clk) begin
    if (exe.valid) begin
      wbRd   <= exe.rd;
      wbData <= aluOut;
    end
  end

  // Register file write one edge after retire
  assign wrEn        = wbWrites;
  assign wrAddr      = wbRd;
  assign wrData      = wbData;
  assign retire      = wbValid;
  assign retireRd    = wbRd;
  assign retireData  = wbData;
  assign retireWrite = wbWrites;

endmodule

/* hw/armDatapath.sv */
`timescale 1ns/1ps
`include "dp_defs.svh"

module armDatapath (
  input  logic                clk,
  input  logic                arstN,
  input  logic                issue,
  input  logic [`DP_XLEN-1:0] instr,
  output logic                retire,
  output logic [3:0]          retireRd,
  output logic [`DP_XLEN-1:0] retireData,
  output logic                retireWrite,
  output logic [3:0]          flags
);

  // Register file ports
  logic [3:0]          rdAddrA;
  logic [3:0]          rdAddrB;
  logic [`DP_XLEN-1:0] rdDataA;
  logic [`DP_XLEN-1:0] rdDataB;
  logic                wrEn;
  logic [3:0]          wrAddr;
  logic [`DP_XLEN-1:0] wrData;

  // Decode to execute bundle
  stageIf exIf ();

  regFile uRegFile (
    .clk     (clk),
    .arstN   (arstN),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrData  (wrData),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  operandDecode uDecode (
    .clk     (clk),
    .arstN   (arstN),
    .issue   (issue),
    .instr   (instr),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .dec     (exIf.dec)
  );

  // Execute and writeback, flags shown as NZCV
  execStage uExec (
    .clk         (clk),
    .arstN       (arstN),
    .exe         (exIf.exe),
    .wrEn        (wrEn),
    .wrAddr      (wrAddr),
    .wrData      (wrData),
    .retire      (retire),
    .retireRd    (retireRd),
    .retireData  (retireData),
    .retireWrite (retireWrite),
    .flags       (flags)
  );

endmodule

/* testbench/datapath_sva.sv */
`timescale 1ns/1ps
`include "dp_defs.svh"

// Protocol checks on the datapath top level
module datapath_sva (
  input logic                clk,
  input logic                arstN,
  input logic                issue,
  input logic                retire,
  input logic [`DP_XLEN-1:0] retireData
);

  // Number of failed assertions
  int failCount = 0;

  // Pipeline is empty for two edges after reset release
  assert property (@(posedge clk) $rose(arstN) |-> !retire ##1 !retire)
    else begin
      $error("retire went high right after reset");
      failCount++;
    end

  // Fixed two-edge latency from issue to retire
  assert property (@(posedge clk) disable iff (!arstN) retire |-> $past(issue, 2))
    else begin
      $error("retire without an issue two cycles earlier");
      failCount++;
    end

  // Retired data is always known
  assert property (@(posedge clk) disable iff (!arstN) retire |-> !$isunknown(retireData))
    else begin
      $error("retireData unknown while retire is high");
      failCount++;
    end

endmodule

bind armDatapath datapath_sva sva (
  .clk        (clk),
  .arstN      (arstN),
  .issue      (issue),
  .retire     (retire),
  .retireData (retireData)
);

/* testbench/tbDatapath.sv */
`timescale 1ns/1ps
`include "dp_defs.svh"

module tbDatapath;

  // Test 6 adds up to maxGap idle cycles per instruction
  localparam int numInstr = 16 + 32 + 60 + 60 + 12 + 40;
  localparam int gapInstr = 40;
  localparam int maxGap   = 3;
  localparam int limitNs  = (numInstr + gapInstr * maxGap + 50) * 4;

  typedef struct packed {
    logic [3:0]          rd;
    logic [`DP_XLEN-1:0] data;
    logic                wr;
    logic [3:0]          flags;
    logic [31:0]         cyc;
  } retireRec_t;

  logic                clk = 1'b0;
  logic                arstN;
  logic                issue;
  logic [`DP_XLEN-1:0] instr;
  logic                retire;
  logic [3:0]          retireRd;
  logic [`DP_XLEN-1:0] retireData;
  logic                retireWrite;
  logic [3:0]          flags;

  // Architectural model of the registers and the NZCV flags with n in bit 3
  logic [`DP_XLEN-1:0] mRegs [16];
  logic [3:0]          mFlags;
  retireRec_t          expQ [$];
  retireRec_t          monRec;
  logic [31:0]         cyc = '0;
  int                  errCount = 0;
  int                  checkCount = 0;
  int                  errBefore;
  logic [3:0]          arithOps [10] = '{dpPkg::opAdd, dpPkg::opAdc, dpPkg::opSub,
                                         dpPkg::opRsb, dpPkg::opSbc, dpPkg::opRsc,
                                         dpPkg::opCmp, dpPkg::opCmn, dpPkg::opTst,
                                         dpPkg::opTeq};

  armDatapath dut (
    .clk         (clk),
    .arstN       (arstN),
    .issue       (issue),
    .instr       (instr),
    .retire      (retire),
    .retireRd    (retireRd),
    .retireData  (retireData),
    .retireWrite (retireWrite),
    .flags       (flags)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // ==============================
  // Encoders and reference model
  // ==============================

  function automatic logic [31:0] encImm(input logic [3:0] op, input logic s,
      input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rot, input logic [7:0] imm8);
    return {4'he, 2'b00, 1'b1, op, s, rn, rd, rot, imm8};
  endfunction

  // Bit 4 is random since the datapath ignores it
  function automatic logic [31:0] encReg(input logic [3:0] op, input logic s,
      input logic [3:0] rn, input logic [3:0] rd, input logic [4:0] amt, input logic [1:0] sh,
      input logic [3:0] rm);
    return {4'he, 2'b00, 1'b0, op, s, rn, rd, amt, sh, 1'($urandom_range(1)), rm};
  endfunction

  function automatic logic [31:0] randInstr(input logic [3:0] op, input logic s,
      input int pool, input logic useImm);
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] rm;
    rn = 4'($urandom_range(pool - 1));
    rd = 4'($urandom_range(pool - 1));
    rm = 4'($urandom_range(pool - 1));
    if (useImm) begin
      return encImm(op, s, rn, rd, 4'($urandom), 8'($urandom));
    end
    return encReg(op, s, rn, rd, 5'($urandom), 2'($urandom), rm);
  endfunction

  // One bit per step with the carry taken from the last bit out
  task automatic shiftOperand(input logic [31:0] val, input logic [1:0] kind,
      input logic [4:0] amt, output logic [31:0] res, output logic carry);
    int n;
    res   = val;
    carry = mFlags[1];
    // LSR #0 and ASR #0 encode a shift of 32
    n     = (amt == 0 && (kind == 1 || kind == 2)) ? 32 : amt;
    if (kind == 3 && amt == 0) begin
      carry = val[0];
      res   = {mFlags[1], val[31:1]};
    end else begin
      repeat (n) begin
        case (kind)
          2'd0: begin
            carry = res[31];
            res   = res << 1;
          end
          2'd1: begin
            carry = res[0];
            res   = res >> 1;
          end
          2'd2: begin
            carry = res[0];
            res   = {res[31], res[31:1]};
          end
          default: begin
            carry = res[0];
            res   = {res[0], res[31:1]};
          end
        endcase
      end
    end
  endtask

  // ARM AddWithCarry where C = 1 means no borrow
  task automatic addCarry(input logic [31:0] x, input logic [31:0] y, input logic cin,
      output logic [31:0] res, output logic c, output logic v);
    logic [32:0] total;
    total = {1'b0, x} + {1'b0, y} + 33'(cin);
    res   = total[31:0];
    c     = total[32];
    v     = (x[31] == y[31]) && (res[31] != x[31]);
  endtask

  task automatic modelStep(input logic [31:0] w);
    dpPkg::aluOp_e op;
    logic [31:0]   a;
    logic [31:0]   b;
    logic          sc;
    logic [31:0]   res;
    logic          c;
    logic          v;
    retireRec_t    rec;
    op = dpPkg::aluOp_e'(w[24:21]);
    a  = mRegs[w[19:16]];
    if (w[25]) begin
      b = {24'd0, w[7:0]};
      repeat ({w[11:8], 1'b0})
        b = {b[0], b[31:1]};
      // Carry from bit 31 only when the immediate was rotated
      sc = (w[11:8] != 4'd0) ? b[31] : mFlags[1];
    end else begin
      shiftOperand(mRegs[w[3:0]], w[6:5], w[11:7], b, sc);
    end
    c = sc;
    v = mFlags[0];
    case (op)
      dpPkg::opAnd, dpPkg::opTst: res = a & b;
      dpPkg::opEor, dpPkg::opTeq: res = a ^ b;
      dpPkg::opSub, dpPkg::opCmp: addCarry(a, ~b, 1'b1, res, c, v);
      dpPkg::opRsb: addCarry(b, ~a, 1'b1, res, c, v);
      dpPkg::opAdd, dpPkg::opCmn: addCarry(a, b, 1'b0, res, c, v);
      dpPkg::opAdc: addCarry(a, b, mFlags[1], res, c, v);
      dpPkg::opSbc: addCarry(a, ~b, mFlags[1], res, c, v);
      dpPkg::opRsc: addCarry(b, ~a, mFlags[1], res, c, v);
      dpPkg::opOrr: res = a | b;
      dpPkg::opMov: res = b;
      dpPkg::opBic: res = a & ~b;
      default: res = ~b;
    endcase
    if (w[20]) begin
      mFlags = {res[31], (res == 32'd0), c, v};
    end
    rec.rd    = w[15:12];
    rec.data  = res;
    rec.wr    = !(op inside {dpPkg::opTst, dpPkg::opTeq, dpPkg::opCmp, dpPkg::opCmn});
    rec.flags = mFlags;
    rec.cyc   = cyc;
    if (rec.wr) begin
      mRegs[rec.rd] = res;
    end
    expQ.push_back(rec);
  endtask

  // ==============================
  // Stimulus and checking
  // ==============================

  // Starts on a falling edge and returns on the next one
  task automatic sendInstr(input logic [31:0] w);
    modelStep(w);
    issue = 1'b1;
    instr = w;
    @(negedge clk);
    issue = 1'b0;
  endtask

  task automatic checkField(input string name, input logic [31:0] expVal,
      input logic [31:0] actVal);
    checkCount++;
    assert (actVal === expVal) else begin
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
      errCount++;
    end
  endtask

  task automatic finishTest(input int num, input string name);
    int waitCycles;
    waitCycles = 0;
    while (expQ.size() != 0 && waitCycles < 8) begin
      @(negedge clk);
      waitCycles++;
    end
    $display("Test %0d %s: %0d errors", num, name, errCount - errBefore);
    errBefore = errCount;
  endtask

  // Each retirement is compared with the front of the queue
  always @(negedge clk) begin
    if (arstN && retire) begin
      checkCount++;
      assert (expQ.size() != 0) else begin
        $display("Error at %0t ns: retire seen with no instruction outstanding", $time);
        errCount++;
      end
      if (expQ.size() != 0) begin
        monRec = expQ.pop_front();
        checkField("retireRd", 32'(monRec.rd), 32'(retireRd));
        checkField("retireData", monRec.data, retireData);
        checkField("retireWrite", 32'(monRec.wr), 32'(retireWrite));
        checkField("flags", 32'(monRec.flags), 32'(flags));
        checkField("latency", monRec.cyc + 2, cyc);
      end
    end
  end

  initial begin
    #(limitNs);
    $display("Timeout: run still busy after %0d ns", limitNs);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(34));
    arstN     = 1'b0;
    issue     = 1'b0;
    instr     = '0;
    mFlags    = '0;
    errBefore = 0;
    for (int i = 0; i < 16; i++) begin
      mRegs[i] = '0;
    end
    repeat (3) @(negedge clk);
    arstN = 1'b1;

    // Quiet pipeline and zeroed state after reset
    repeat (4) begin
      @(negedge clk);
      checkField("retire", 32'd0, 32'(retire));
      checkField("flags", 32'd0, 32'(flags));
    end
    for (int i = 0; i < 16; i++) begin
      sendInstr(encImm(dpPkg::opOrr, 1'b0, 4'(i), 4'(i), 4'd0, 8'd0));
    end
    finishTest(1, "reset state");

    for (int i = 0; i < 32; i++) begin
      sendInstr(encImm($urandom_range(1) ? dpPkg::opMov : dpPkg::opMvn, 1'($urandom),
                       4'($urandom), 4'(i % 16), 4'($urandom), 8'($urandom)));
    end
    finishTest(2, "immediate loads");

    // A pool of four registers makes dependencies at distance 1 to 3 common
    for (int i = 0; i < 60; i++) begin
      sendInstr(randInstr(4'($urandom), 1'($urandom), 4, 1'b0));
    end
    finishTest(3, "forwarding");

    for (int i = 0; i < 60; i++) begin
      sendInstr(randInstr(arithOps[$urandom_range(9)], 1'b1, 6, 1'($urandom)));
    end
    finishTest(4, "arithmetic flags");

    // r1 = 0x80000001 is negative and odd
    sendInstr(encImm(dpPkg::opMov, 1'b1, 4'd0, 4'd1, 4'd1, 8'h06));
    sendInstr(encReg(dpPkg::opMov, 1'b1, 4'd0, 4'd3, 5'd0, dpPkg::shLsl, 4'd1));
    sendInstr(encReg(dpPkg::opMov, 1'b1, 4'd0, 4'd4, 5'd0, dpPkg::shLsr, 4'd1));
    sendInstr(encReg(dpPkg::opMov, 1'b1, 4'd0, 4'd5, 5'd0, dpPkg::shAsr, 4'd1));
    sendInstr(encImm(dpPkg::opCmp, 1'b1, 4'd1, 4'd0, 4'd0, 8'h00));
    sendInstr(encReg(dpPkg::opMov, 1'b1, 4'd0, 4'd6, 5'd0, dpPkg::shRor, 4'd1));
    sendInstr(encReg(dpPkg::opAnd, 1'b1, 4'd1, 4'd7, 5'd0, dpPkg::shRor, 4'd1));
    sendInstr(encReg(dpPkg::opMov, 1'b1, 4'd0, 4'd8, 5'd31, dpPkg::shLsl, 4'd1));
    sendInstr(encReg(dpPkg::opMov, 1'b1, 4'd0, 4'd9, 5'd31, dpPkg::shLsr, 4'd1));
    sendInstr(encReg(dpPkg::opMov, 1'b1, 4'd0, 4'd10, 5'd31, dpPkg::shAsr, 4'd1));
    sendInstr(encReg(dpPkg::opEor, 1'b1, 4'd1, 4'd11, 5'd31, dpPkg::shRor, 4'd1));
    sendInstr(encReg(dpPkg::opTst, 1'b1, 4'd1, 4'd0, 5'd0, dpPkg::shLsr, 4'd1));
    finishTest(5, "shift edge cases");

    for (int i = 0; i < gapInstr; i++) begin
      sendInstr(randInstr(4'($urandom), 1'($urandom), 8, 1'($urandom)));
      repeat ($urandom_range(maxGap)) @(negedge clk);
    end
    finishTest(6, "issue gaps");

    assert (expQ.size() == 0) else begin
      $display("Error: %0d expected retirements never arrived", expQ.size());
      errCount++;
    end
    // Bound protocol assertions keep their own failure count
    assert (dut.sva.failCount == 0) else begin
      $display("Error: %0d protocol assertions failed", dut.sva.failCount);
      errCount++;
    end
    $display("Summary: 6 tests, %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+hw
hw/dpPkg.sv
hw/stageIf.sv
hw/regFile.sv
hw/operandDecode.sv
hw/barrelShifter.sv
hw/aluUnit.sv
hw/execStage.sv
hw/armDatapath.sv
testbench/datapath_sva.sv
testbench/tbDatapath.sv
